// ==== project.f ====
src/ooo_pkg.sv
src/issue_stage.sv
src/reg_status_file.sv
src/alu_station.sv
src/alu_unit.sv
src/reorder_buffer.sv
src/ooo_core_top.sv
verif/core_asserts.sv
verif/core_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1

log_file=sim.log
rm -f "$log_file"

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module core_tb -f project.f -o core_sim
if [ $? -ne 0 ]; then
  echo "verilator compile failed"
  exit 1
fi

./obj_dir/core_sim 2>&1 | tee "$log_file"
status=${PIPESTATUS[0]}
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "TEST PASSED" "$log_file"; then
  echo "simulation passed"
  exit 0
fi
echo "pass message not found in $log_file"
exit 1

// ==== verif/core_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module core_tb;
  import ooo_pkg::*;

  localparam int IN_DEPTH = 4;
  localparam int RS_DEPTH = 4;
  localparam int CYCLES_PER_INST = 200;

  logic clk_in;
  logic rst;
  logic inst_valid;
  rv_inst_u inst;
  logic inst_credit;
  logic commit_valid;
  commit_t commit;

  // architectural state of the reference model
  logic [XLEN-1:0] ref_regs [NUM_REGS];
  commit_t exp_q [$];
  int sent_total;
  int ret_total;
  int commit_total;
  int cycle_count;
  int stall_cycles;
  int error_count;
  int tests_run;
  int test_base;
  bit verdict_done;

  ooo_core_top #(
    .IN_DEPTH(IN_DEPTH),
    .RS_DEPTH(RS_DEPTH)
  ) dut_i (
    .clk_in(clk_in), .rst(rst),
    .inst_valid(inst_valid), .inst(inst), .inst_credit(inst_credit),
    .commit_valid(commit_valid), .commit(commit)
  );

  always #5 clk_in = ~clk_in;

  task automatic compare_commit(commit_t expected, commit_t actual);
    if (actual.rd !== expected.rd) begin
      $display("** Error: commit.rd expected %h actual %h", expected.rd, actual.rd);
      error_count++;
    end
    if (actual.value !== expected.value) begin
      $display("** Error: commit.value expected %h actual %h", expected.value, actual.value);
      error_count++;
    end
  endtask

  task automatic compare_credit(string name, int expected, int actual);
    if (actual != expected) begin
      $display("** Error: %s expected %h actual %h", name, expected, actual);
      error_count++;
    end
  endtask

  // credit returns and commits, sampled on the rising edge
  always @(posedge clk_in) begin : monitor
    commit_t expected;
    cycle_count++;
    if (!rst && inst_credit) begin
      ret_total++;
    end
    if (!rst && commit_valid) begin
      commit_total++;
      if (exp_q.size() == 0) begin
        $display("commit seen with no instruction outstanding, rd %0d", commit.rd);
        error_count++;
      end else begin
        expected = exp_q.pop_front();
        compare_commit(expected, commit);
      end
    end
  end

  function automatic rv_inst_u r_form(logic [6:0] f7, reg_id_t src2, reg_id_t src1,
                                      logic [2:0] f3, reg_id_t dst);
    rv_inst_u w;
    w.r.funct7 = f7;
    w.r.rs2 = src2;
    w.r.rs1 = src1;
    w.r.funct3 = f3;
    w.r.rd = dst;
    w.r.opcode = OPC_OP;
    return w;
  endfunction

  function automatic rv_inst_u i_form(logic [11:0] imm, reg_id_t src1, logic [2:0] f3,
                                      reg_id_t dst);
    rv_inst_u w;
    w.i.imm12 = imm;
    w.i.rs1 = src1;
    w.i.funct3 = f3;
    w.i.rd = dst;
    w.i.opcode = OPC_OP_IMM;
    return w;
  endfunction

  function automatic reg_id_t pick_reg();
    return reg_id_t'($urandom_range(0, 7));
  endfunction

  // one in ten is an unsupported opcode, the rest split between r and i forms
  function automatic rv_inst_u random_inst();
    rv_inst_u w;
    int kind;
    logic [2:0] f3;
    logic [11:0] imm;
    logic [6:0] f7;
    kind = int'($urandom_range(0, 9));
    f3 = 3'($urandom_range(0, 7));
    imm = 12'($urandom);
    if (kind == 0) begin
      w = $urandom;
      if (w.r.opcode == OPC_OP || w.r.opcode == OPC_OP_IMM) begin
        w.r.opcode[6] = 1'b1;
      end
    end else if (kind < 5) begin
      f7 = F7_BASE;
      if ((f3 == 3'b000 || f3 == 3'b101) && $urandom_range(0, 1) == 1) begin
        f7 = F7_ALT;
      end
      w = r_form(f7, pick_reg(), pick_reg(), f3, pick_reg());
    end else begin
      if (f3 == 3'b001) begin
        imm[11:5] = F7_BASE;
      end
      if (f3 == 3'b101) begin
        imm[11:5] = ($urandom_range(0, 1) == 1) ? F7_ALT : F7_BASE;
      end
      w = i_form(imm, pick_reg(), f3, pick_reg());
    end
    return w;
  endfunction

  // RV32I rules, applied in program order
  task automatic predict(input rv_inst_u word, output commit_t expected);
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [XLEN-1:0] res;
    logic [6:0] hi;
    logic [2:0] f3;
    logic is_r;
    logic is_i;
    logic alt;
    logic ok;
    f3 = word.r.funct3;
    is_r = word.r.opcode == OPC_OP;
    is_i = word.i.opcode == OPC_OP_IMM;
    a = ref_regs[word.r.rs1];
    if (is_r) begin
      b = ref_regs[word.r.rs2];
      hi = word.r.funct7;
    end else begin
      b = {{(XLEN - 12){word.i.imm12[11]}}, word.i.imm12};
      hi = word.i.imm12[11:5];
    end
    alt = hi == 7'h20;
    if (is_r) begin
      ok = (hi == 7'h00) || (alt && (f3 == 3'b000 || f3 == 3'b101));
    end else if (is_i && (f3 == 3'b001 || f3 == 3'b101)) begin
      ok = (hi == 7'h00) || (alt && f3 == 3'b101);
    end else begin
      ok = is_i;
    end
    case (f3)
      3'b000: res = (is_r && alt) ? a - b : a + b;
      3'b001: res = a << b[4:0];
      3'b010: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'b011: res = (a < b) ? 32'd1 : 32'd0;
      3'b100: res = a ^ b;
      3'b101: begin
        if (alt) begin
          res = $signed(a) >>> b[4:0];
        end else begin
          res = a >> b[4:0];
        end
      end
      3'b110: res = a | b;
      default: res = a & b;
    endcase
    expected.rd = ok ? word.r.rd : 5'd0;
    expected.value = ok ? res : '0;
    if (ok && word.r.rd != 5'd0) begin
      ref_regs[word.r.rd] = res;
    end
  endtask

  task automatic send_inst(rv_inst_u word);
    commit_t expected;
    @(negedge clk_in);
    while (IN_DEPTH - (sent_total - ret_total) <= 0) begin
      inst_valid = 1'b0;
      stall_cycles++;
      @(negedge clk_in);
    end
    predict(word, expected);
    exp_q.push_back(expected);
    inst_valid = 1'b1;
    inst = word;
    sent_total++;
  endtask

  task automatic drain();
    @(negedge clk_in);
    inst_valid = 1'b0;
    while (exp_q.size() != 0) begin
      @(negedge clk_in);
    end
  endtask

  task automatic finish_test(string name);
    drain();
    tests_run++;
    $display("test %s done, %0d errors", name, error_count - test_base);
    test_base = error_count;
  endtask

  task automatic test_alu_ops();
    send_inst(i_form(12'hffb, 5'd0, 3'b000, 5'd1));
    send_inst(i_form(12'h007, 5'd0, 3'b000, 5'd2));
    send_inst(i_form(12'h800, 5'd0, 3'b000, 5'd3));
    for (int f = 0; f < 8; f++) begin
      send_inst(r_form(F7_BASE, 5'd2, 5'd1, 3'(f), 5'(4 + f)));
    end
    send_inst(r_form(F7_ALT, 5'd2, 5'd1, 3'b000, 5'd12));
    send_inst(r_form(F7_ALT, 5'd2, 5'd1, 3'b101, 5'd13));
    send_inst(r_form(F7_BASE, 5'd1, 5'd3, 3'b011, 5'd14));
    send_inst(r_form(F7_BASE, 5'd1, 5'd3, 3'b010, 5'd15));
    // shift amounts of 3, negative immediates elsewhere
    for (int f = 0; f < 8; f++) begin
      send_inst(i_form((f == 1 || f == 5) ? 12'h003 : 12'hff0, 5'd1, 3'(f), 5'(16 + f)));
    end
    send_inst(i_form(12'h403, 5'd1, 3'b101, 5'd24));
    finish_test("alu_ops");
  endtask

  task automatic test_raw_chain();
    send_inst(i_form(12'h003, 5'd0, 3'b000, 5'd5));
    for (int n = 0; n < 6; n++) begin
      send_inst(r_form(F7_BASE, 5'd5, 5'd5, 3'b000, 5'd5));
    end
    send_inst(r_form(F7_ALT, 5'd1, 5'd5, 3'b000, 5'd6));
    send_inst(r_form(F7_BASE, 5'd5, 5'd6, 3'b100, 5'd7));
    send_inst(r_form(F7_BASE, 5'd6, 5'd7, 3'b010, 5'd8));
    send_inst(r_form(F7_ALT, 5'd2, 5'd7, 3'b101, 5'd9));
    for (int n = 0; n < 4; n++) begin
      send_inst(i_form(12'h001, 5'd9, 3'b000, 5'd9));
    end
    finish_test("raw_chain");
  endtask

  task automatic test_commit_order();
    send_inst(i_form(12'h001, 5'd0, 3'b000, 5'd11));
    for (int n = 0; n < 12; n++) begin
      send_inst(r_form(F7_BASE, 5'd11, 5'd11, 3'b000, 5'd11));
    end
    // independent work that finishes before the chain
    for (int n = 0; n < 6; n++) begin
      send_inst(i_form(12'(n + 10), 5'd0, 3'b000, 5'(12 + n)));
    end
    finish_test("commit_order");
  endtask

  task automatic test_credit_flow();
    int stalls_before;
    compare_credit("credits held", IN_DEPTH, IN_DEPTH - (sent_total - ret_total));
    stalls_before = stall_cycles;
    for (int n = 0; n < IN_DEPTH; n++) begin
      send_inst(i_form(12'(n + 1), 5'd0, 3'b000, 5'(20 + n)));
    end
    compare_credit("stall cycles", 0, stall_cycles - stalls_before);
    drain();
    compare_credit("inst_credit pulses", sent_total, ret_total);
    // dependent burst, so the station backs up and credits are withheld
    for (int n = 0; n < 40; n++) begin
      send_inst(i_form(12'($urandom), 5'd3, (n % 2 == 1) ? 3'b100 : 3'b000, 5'd3));
    end
    drain();
    compare_credit("inst_credit pulses", sent_total, ret_total);
    compare_credit("commit count", sent_total, commit_total);
    finish_test("credit_flow");
  endtask

  task automatic test_random_program();
    send_inst(i_form(12'h055, 5'd0, 3'b000, 5'd0));
    send_inst(r_form(F7_BASE, 5'd0, 5'd0, 3'b110, 5'd1));
    for (int n = 0; n < 200; n++) begin
      send_inst(random_inst());
    end
    finish_test("random_program");
  endtask

  initial begin : watchdog
    wait (cycle_count > CYCLES_PER_INST * (sent_total + 16));
    verdict_done = 1'b1;
    $display("timeout after %0d cycles with %0d commits outstanding", cycle_count,
             exp_q.size());
    $display("TEST FAILED");
    $finish;
  end

  initial begin
    clk_in = 1'b0;
    rst = 1'b1;
    inst_valid = 1'b0;
    inst = '0;
    for (int i = 0; i < NUM_REGS; i++) begin
      ref_regs[i] = '0;
    end
    void'($urandom(32'ha45));
    repeat (10) @(posedge clk_in);
    @(negedge clk_in);
    rst = 1'b0;
    test_alu_ops();
    test_raw_chain();
    test_commit_order();
    test_credit_flow();
    test_random_program();
    $display("tests %0d, instructions %0d, commits %0d, errors %0d", tests_run, sent_total,
             commit_total, error_count);
    verdict_done = 1'b1;
    if (error_count == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  // run stopped before any verdict, for instance by an assertion
  final begin
    if (!verdict_done) begin
      $display("TEST FAILED");
    end
  end

endmodule

`default_nettype wire

// ==== verif/core_asserts.sv ====
`timescale 1ns/1ps
`default_nettype none

module core_asserts (
  input logic               clk_in,
  input logic               rst,
  input logic               inst_valid,
  input logic               inst_credit,
  input logic               commit_valid,
  input ooo_pkg::commit_t   commit,
  input ooo_pkg::rob_tag_t  commit_tag,
  input logic               rs_push,
  input ooo_pkg::rs_entry_t rs_entry
);
  import ooo_pkg::*;

  int accepted;
  int returned;
  // which rob tags currently hold a nop
  logic [ROB_DEPTH-1:0] nop_q;

  always_ff @(posedge clk_in) begin
    if (rst) begin
      accepted <= 0;
      returned <= 0;
      nop_q <= '0;
    end else begin
      accepted <= accepted + int'(inst_valid);
      returned <= returned + int'(inst_credit);
      if (rs_push) begin
        nop_q[rs_entry.dest] <= rs_entry.op == ALU_NOP;
      end
    end
  end

  quiet_in_reset: assert property (@(posedge clk_in)
    rst && $past(rst) |-> !commit_valid && !inst_credit)
    else $error("commit_valid or inst_credit high during reset");

  credits_bounded: assert property (@(posedge clk_in) disable iff (rst)
    returned + int'(inst_credit) <= accepted)
    else $error("more inst_credit pulses than accepted instructions");

  // a nop must leave the rob with rd 0
  nop_commits_rd0: assert property (@(posedge clk_in) disable iff (rst)
    commit_valid && nop_q[commit_tag] |-> commit.rd == '0)
    else $error("nop committed with nonzero rd");

endmodule

bind ooo_core_top core_asserts asserts_i (
  .clk_in(clk_in), .rst(rst),
  .inst_valid(inst_valid), .inst_credit(inst_credit), .commit_valid(commit_valid),
  .commit(commit), .commit_tag(commit_tag),
  .rs_push(rs_push), .rs_entry(rs_entry)
);

`default_nettype wire

// ==== src/ooo_core_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module ooo_core_top #(
  parameter int IN_DEPTH = 4,
  parameter int RS_DEPTH = 4
) (
  input  logic              clk_in,
  input  logic              rst,
  input  logic              inst_valid,
  input  ooo_pkg::rv_inst_u inst,
  output logic              inst_credit,
  output logic              commit_valid,
  output ooo_pkg::commit_t  commit
);
  import ooo_pkg::*;

  reg_id_t rs1;
  reg_id_t rs2;
  operand_t src1;
  operand_t src2;
  logic rename_en;
  reg_id_t rename_rd;
  rob_tag_t rename_tag;
  rob_tag_t rob_tail;
  logic rob_push;
  reg_id_t push_rd;
  logic rob_credit;
  rob_tag_t query_j;
  rob_tag_t query_k;
  operand_t fwd_j;
  operand_t fwd_k;
  cdb_t cdb;
  logic rs_push;
  rs_entry_t rs_entry;
  logic rs_credit;
  logic exec_valid;
  rs_entry_t exec;
  rob_tag_t commit_tag;

  issue_stage #(
    .IN_DEPTH(IN_DEPTH),
    .RS_DEPTH(RS_DEPTH)
  ) issue_i (
    .clk_in(clk_in), .rst(rst),
    .inst_valid(inst_valid), .inst(inst), .inst_credit(inst_credit),
    .src1(src1), .src2(src2), .rs1(rs1), .rs2(rs2),
    .rename_en(rename_en), .rename_rd(rename_rd), .rename_tag(rename_tag),
    .rob_tail(rob_tail), .rob_push(rob_push), .push_rd(push_rd), .rob_credit(rob_credit),
    .query_j(query_j), .query_k(query_k), .fwd_j(fwd_j), .fwd_k(fwd_k),
    .cdb(cdb), .rs_push(rs_push), .entry(rs_entry), .rs_credit(rs_credit)
  );

  reg_status_file regs_i (
    .clk_in(clk_in), .rst(rst),
    .rs1(rs1), .rs2(rs2), .src1(src1), .src2(src2),
    .rename_en(rename_en), .rename_rd(rename_rd), .rename_tag(rename_tag),
    .commit_valid(commit_valid), .commit(commit), .commit_tag(commit_tag)
  );

  alu_station #(
    .RS_DEPTH(RS_DEPTH)
  ) station_i (
    .clk_in(clk_in), .rst(rst),
    .rs_push(rs_push), .entry(rs_entry), .cdb(cdb),
    .exec_valid(exec_valid), .exec(exec), .rs_credit(rs_credit)
  );

  alu_unit alu_i (
    .clk_in(clk_in), .rst(rst),
    .exec_valid(exec_valid), .exec(exec), .cdb(cdb)
  );

  reorder_buffer rob_i (
    .clk_in(clk_in), .rst(rst),
    .rob_push(rob_push), .push_rd(push_rd), .rob_tail(rob_tail), .rob_credit(rob_credit),
    .cdb(cdb), .query_j(query_j), .query_k(query_k), .fwd_j(fwd_j), .fwd_k(fwd_k),
    .commit_valid(commit_valid), .commit(commit), .commit_tag(commit_tag)
  );

endmodule

`default_nettype wire

// ==== src/reorder_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module reorder_buffer (
  input  logic              clk_in,
  input  logic              rst,
  input  logic              rob_push,
  input  ooo_pkg::reg_id_t  push_rd,
  output ooo_pkg::rob_tag_t rob_tail,
  output logic              rob_credit,
  input  ooo_pkg::cdb_t     cdb,
  input  ooo_pkg::rob_tag_t query_j,
  input  ooo_pkg::rob_tag_t query_k,
  output ooo_pkg::operand_t fwd_j,
  output ooo_pkg::operand_t fwd_k,
  output logic              commit_valid,
  output ooo_pkg::commit_t  commit,
  output ooo_pkg::rob_tag_t commit_tag
);
  import ooo_pkg::*;

  reg_id_t rd_q [ROB_DEPTH];
  logic [XLEN-1:0] value_q [ROB_DEPTH];
  logic [ROB_DEPTH-1:0] done_q;
  rob_tag_t head_q;
  rob_tag_t tail_q;

  assign rob_tail = tail_q;

  // head retires as soon as its result is in
  assign commit_valid = done_q[head_q];
  assign commit.rd = rd_q[head_q];
  assign commit.value = value_q[head_q];
  assign commit_tag = head_q;
  assign rob_credit = commit_valid;

  // operand lookup for tagged sources at issue
  always_comb begin
    fwd_j.ready = done_q[query_j];
    fwd_j.tag = query_j;
    fwd_j.value = value_q[query_j];
    fwd_k.ready = done_q[query_k];
    fwd_k.tag = query_k;
    fwd_k.value = value_q[query_k];
  end

  // pointers wrap on their own, depth is a power of two
  always_ff @(posedge clk_in) begin
    if (rst) begin
      head_q <= '0;
      tail_q <= '0;
      done_q <= '0;
    end else begin
      if (cdb.valid) begin
        done_q[cdb.tag] <= 1'b1;
      end
      if (commit_valid) begin
        done_q[head_q] <= 1'b0;
        head_q <= head_q + 1'b1;
      end
      if (rob_push) begin
        done_q[tail_q] <= 1'b0;
        tail_q <= tail_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_in) begin
    if (rob_push) begin
      rd_q[tail_q] <= push_rd;
    end
    if (cdb.valid) begin
      value_q[cdb.tag] <= cdb.value;
    end
  end

endmodule

`default_nettype wire

// ==== src/alu_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu_unit (
  input  logic               clk_in,
  input  logic               rst,
  input  logic               exec_valid,
  input  ooo_pkg::rs_entry_t exec,
  output ooo_pkg::cdb_t      cdb
);
  import ooo_pkg::*;

  logic [XLEN-1:0] a;
  logic [XLEN-1:0] b;
  logic [XLEN-1:0] result;
  logic [4:0] shamt;

  always_comb begin
    a = exec.j.value;
    b = exec.k.value;
    shamt = b[4:0];
    case (exec.op)
      ALU_ADD: result = a + b;
      ALU_SUB: result = a - b;
      ALU_SLL: result = a << shamt;
      ALU_SLT: result = XLEN'($signed(a) < $signed(b));
      ALU_SLTU: result = XLEN'(a < b);
      ALU_XOR: result = a ^ b;
      ALU_SRL: result = a >> shamt;
      ALU_SRA: result = XLEN'($signed(a) >>> shamt);
      ALU_OR: result = a | b;
      ALU_AND: result = a & b;
      default: result = '0;
    endcase
  end

  // single cycle, result appears on the bus the cycle after dispatch
  always_ff @(posedge clk_in) begin
    cdb.tag <= exec.dest;
    cdb.value <= result;
    if (rst) begin
      cdb.valid <= 1'b0;
    end else begin
      cdb.valid <= exec_valid;
    end
  end

endmodule

`default_nettype wire

// ==== src/alu_station.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu_station #(
  parameter int RS_DEPTH = 4
) (
  input  logic               clk_in,
  input  logic               rst,
  input  logic               rs_push,
  input  ooo_pkg::rs_entry_t entry,
  input  ooo_pkg::cdb_t      cdb,
  output logic               exec_valid,
  output ooo_pkg::rs_entry_t exec,
  output logic               rs_credit
);
  import ooo_pkg::*;

  localparam int IDX_W = (RS_DEPTH > 1) ? $clog2(RS_DEPTH) : 1;
  localparam int CNT_W = $clog2(RS_DEPTH + 1);

  // collapsing queue, slot 0 holds the oldest entry
  rs_entry_t slot_q [RS_DEPTH];
  rs_entry_t slot_d [RS_DEPTH];
  rs_entry_t woken [RS_DEPTH];
  logic [CNT_W-1:0] count_q;
  logic [CNT_W-1:0] fill;
  logic [IDX_W-1:0] sel_idx;
  logic sel_found;

  function automatic operand_t wake(operand_t opnd, cdb_t bus);
    operand_t res;
    res = opnd;
    if (!opnd.ready && bus.valid && bus.tag == opnd.tag) begin
      res.ready = 1'b1;
      res.value = bus.value;
    end
    return res;
  endfunction

  // scan down so the lowest ready index wins
  always_comb begin
    sel_found = 1'b0;
    sel_idx = '0;
    for (int i = RS_DEPTH - 1; i >= 0; i--) begin
      if (CNT_W'(i) < count_q && slot_q[i].j.ready && slot_q[i].k.ready) begin
        sel_found = 1'b1;
        sel_idx = IDX_W'(i);
      end
    end
  end

  assign exec_valid = sel_found;
  assign exec = slot_q[sel_idx];
  assign rs_credit = sel_found;

  always_comb begin
    for (int i = 0; i < RS_DEPTH; i++) begin
      woken[i] = slot_q[i];
      woken[i].j = wake(slot_q[i].j, cdb);
      woken[i].k = wake(slot_q[i].k, cdb);
    end
    slot_d = woken;
    // close the gap left by the dispatched entry
    for (int i = 0; i < RS_DEPTH - 1; i++) begin
      if (sel_found && IDX_W'(i) >= sel_idx) begin
        slot_d[i] = woken[i + 1];
      end
    end
    fill = count_q - CNT_W'(sel_found);
    if (rs_push) begin
      slot_d[IDX_W'(fill)] = entry;
    end
  end

  always_ff @(posedge clk_in) begin
    if (rst) begin
      count_q <= '0;
    end else begin
      count_q <= fill + CNT_W'(rs_push);
    end
  end

  always_ff @(posedge clk_in) begin
    slot_q <= slot_d;
  end

endmodule

`default_nettype wire

// ==== src/reg_status_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module reg_status_file (
  input  logic              clk_in,
  input  logic              rst,
  input  ooo_pkg::reg_id_t  rs1,
  input  ooo_pkg::reg_id_t  rs2,
  output ooo_pkg::operand_t src1,
  output ooo_pkg::operand_t src2,
  input  logic              rename_en,
  input  ooo_pkg::reg_id_t  rename_rd,
  input  ooo_pkg::rob_tag_t rename_tag,
  input  logic              commit_valid,
  input  ooo_pkg::commit_t  commit,
  input  ooo_pkg::rob_tag_t commit_tag
);
  import ooo_pkg::*;

  logic [XLEN-1:0] value_q [NUM_REGS];
  rob_tag_t tag_q [NUM_REGS];
  logic [NUM_REGS-1:0] busy_q;

  function automatic operand_t read_src(reg_id_t r);
    operand_t res;
    res.ready = !busy_q[r];
    res.tag = tag_q[r];
    res.value = value_q[r];
    // x0 is hardwired
    if (r == '0) begin
      res = operand_t'{ready: 1'b1, tag: '0, value: '0};
    end
    return res;
  endfunction

  always_comb begin
    src1 = read_src(rs1);
    src2 = read_src(rs2);
  end

  always_ff @(posedge clk_in) begin
    if (rst) begin
      busy_q <= '0;
      for (int i = 0; i < NUM_REGS; i++) begin
        value_q[i] <= '0;
        tag_q[i] <= '0;
      end
    end else begin
      if (commit_valid && commit.rd != '0) begin
        value_q[commit.rd] <= commit.value;
        // keep busy if a younger instruction owns the register now
        if (tag_q[commit.rd] == commit_tag) begin
          busy_q[commit.rd] <= 1'b0;
        end
      end
      // same-cycle rename wins over the commit above
      if (rename_en && rename_rd != '0) begin
        busy_q[rename_rd] <= 1'b1;
        tag_q[rename_rd] <= rename_tag;
      end
    end
  end

endmodule

`default_nettype wire

// ==== src/issue_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module issue_stage #(
  parameter int IN_DEPTH = 4,
  parameter int RS_DEPTH = 4
) (
  input  logic              clk_in,
  input  logic              rst,
  input  logic              inst_valid,
  input  ooo_pkg::rv_inst_u inst,
  output logic              inst_credit,
  input  ooo_pkg::operand_t src1,
  input  ooo_pkg::operand_t src2,
  output ooo_pkg::reg_id_t  rs1,
  output ooo_pkg::reg_id_t  rs2,
  output logic              rename_en,
  output ooo_pkg::reg_id_t  rename_rd,
  output ooo_pkg::rob_tag_t rename_tag,
  input  ooo_pkg::rob_tag_t rob_tail,
  output logic              rob_push,
  output ooo_pkg::reg_id_t  push_rd,
  input  logic              rob_credit,
  output ooo_pkg::rob_tag_t query_j,
  output ooo_pkg::rob_tag_t query_k,
  input  ooo_pkg::operand_t fwd_j,
  input  ooo_pkg::operand_t fwd_k,
  input  ooo_pkg::cdb_t     cdb,
  output logic              rs_push,
  output ooo_pkg::rs_entry_t entry,
  input  logic              rs_credit
);
  import ooo_pkg::*;

  localparam int PTR_W = (IN_DEPTH > 1) ? $clog2(IN_DEPTH) : 1;
  localparam int QCNT_W = $clog2(IN_DEPTH + 1);
  localparam int RSC_W = $clog2(RS_DEPTH + 1);
  localparam int ROBC_W = $clog2(ROB_DEPTH + 1);

  rv_inst_u queue_mem [IN_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [QCNT_W-1:0] q_count;
  logic [RSC_W-1:0] rs_credits;
  logic [ROBC_W-1:0] rob_credits;
  logic fire;
  rv_inst_u head;
  logic use_imm;
  logic legal;
  logic alt;
  logic is_shift;
  reg_id_t dest_rd;
  logic [XLEN-1:0] imm_val;
  operand_t opnd_j;
  operand_t opnd_k;

  function automatic logic [PTR_W-1:0] next_ptr(logic [PTR_W-1:0] p);
    return (p == PTR_W'(IN_DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  function automatic alu_op_e base_op(logic [2:0] f3, logic use_alt);
    case (f3)
      3'b000: return use_alt ? ALU_SUB : ALU_ADD;
      3'b001: return ALU_SLL;
      3'b010: return ALU_SLT;
      3'b011: return ALU_SLTU;
      3'b100: return ALU_XOR;
      3'b101: return use_alt ? ALU_SRA : ALU_SRL;
      3'b110: return ALU_OR;
      default: return ALU_AND;
    endcase
  endfunction

  // register file first, then a completed rob entry, then this cycle's cdb
  function automatic operand_t resolve(operand_t reg_src, operand_t fwd, cdb_t bus);
    operand_t res;
    res = reg_src;
    if (!reg_src.ready && fwd.ready) begin
      res.ready = 1'b1;
      res.value = fwd.value;
    end else if (!reg_src.ready && bus.valid && bus.tag == reg_src.tag) begin
      res.ready = 1'b1;
      res.value = bus.value;
    end
    return res;
  endfunction

  always_comb begin
    head = queue_mem[rd_ptr];
    imm_val = {{(XLEN - 12){head.i.imm12[11]}}, head.i.imm12};
    is_shift = head.r.funct3[1:0] == 2'b01;
    use_imm = 1'b0;
    legal = 1'b0;
    alt = 1'b0;
    if (head.r.opcode == OPC_OP) begin
      alt = head.r.funct7 == F7_ALT;
      legal = (head.r.funct7 == F7_BASE) ||
              (alt && (head.r.funct3 == 3'b000 || head.r.funct3 == 3'b101));
    end else if (head.i.opcode == OPC_OP_IMM) begin
      use_imm = 1'b1;
      alt = (head.i.funct3 == 3'b101) && (head.i.imm12[11:5] == F7_ALT);
      legal = !is_shift || (head.i.imm12[11:5] == F7_BASE) || alt;
    end
    dest_rd = legal ? head.r.rd : '0;

    opnd_j = resolve(src1, fwd_j, cdb);
    opnd_k = resolve(src2, fwd_k, cdb);
    if (use_imm) begin
      opnd_k = operand_t'{ready: 1'b1, tag: '0, value: imm_val};
    end
    // unsupported word becomes a nop with nothing to wait on
    if (!legal) begin
      opnd_j = operand_t'{ready: 1'b1, tag: '0, value: '0};
      opnd_k = operand_t'{ready: 1'b1, tag: '0, value: '0};
    end

    entry.op = legal ? base_op(head.r.funct3, alt) : ALU_NOP;
    entry.j = opnd_j;
    entry.k = opnd_k;
    entry.dest = rob_tail;
  end

  assign rs1 = head.r.rs1;
  assign rs2 = head.r.rs2;
  assign query_j = src1.tag;
  assign query_k = src2.tag;

  // needs a queued word plus a slot downstream on both sides
  assign fire = (q_count != '0) && (rs_credits != '0) && (rob_credits != '0);

  assign inst_credit = fire;
  assign rs_push = fire;
  assign rob_push = fire;
  assign push_rd = dest_rd;
  assign rename_en = fire;
  assign rename_rd = dest_rd;
  assign rename_tag = rob_tail;

  always_ff @(posedge clk_in) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      q_count <= '0;
      rs_credits <= RSC_W'(RS_DEPTH);
      rob_credits <= ROBC_W'(ROB_DEPTH);
    end else begin
      if (inst_valid) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (fire) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      q_count <= q_count + QCNT_W'(inst_valid) - QCNT_W'(fire);
      rs_credits <= rs_credits + RSC_W'(rs_credit) - RSC_W'(fire);
      rob_credits <= rob_credits + ROBC_W'(rob_credit) - ROBC_W'(fire);
    end
  end

  always_ff @(posedge clk_in) begin
    if (inst_valid) begin
      queue_mem[wr_ptr] <= inst;
    end
  end

endmodule

`default_nettype wire

// ==== src/ooo_pkg.sv ====
`default_nettype none

package ooo_pkg;

  localparam int XLEN = 32;
  localparam int NUM_REGS = 32;
  localparam int ROB_DEPTH = 8;

  typedef logic [$clog2(ROB_DEPTH)-1:0] rob_tag_t;
  typedef logic [4:0] reg_id_t;

  localparam logic [6:0] OPC_OP = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_ALT = 7'b0100000;

  typedef struct packed {
    logic [6:0] funct7;
    reg_id_t rs2;
    reg_id_t rs1;
    logic [2:0] funct3;
    reg_id_t rd;
    logic [6:0] opcode;
  } r_view_t;

  typedef struct packed {
    logic [11:0] imm12;
    reg_id_t rs1;
    logic [2:0] funct3;
    reg_id_t rd;
    logic [6:0] opcode;
  } i_view_t;

  // same word, register or immediate layout
  typedef union packed {
    r_view_t r;
    i_view_t i;
  } rv_inst_u;

  typedef enum logic [3:0] {
    ALU_NOP,
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND
  } alu_op_e;

  typedef struct packed {
    logic ready;
    rob_tag_t tag;
    logic [XLEN-1:0] value;
  } operand_t;

  // immediates travel in k, already ready
  typedef struct packed {
    alu_op_e op;
    operand_t j;
    operand_t k;
    rob_tag_t dest;
  } rs_entry_t;

  typedef struct packed {
    logic valid;
    rob_tag_t tag;
    logic [XLEN-1:0] value;
  } cdb_t;

  typedef struct packed {
    reg_id_t rd;
    logic [XLEN-1:0] value;
  } commit_t;

endpackage

`default_nettype wire
